// File: rtl/qspi_pkg.sv
package qspi_pkg;

    localparam int NIBBLE_W = 4;

    // first nibble after chip select settles
    typedef enum logic [NIBBLE_W-1:0] {
        OP_IDLE        = 4'd0,
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2
    } opcode_e;

    // last nibble of every reply
    typedef enum logic [NIBBLE_W-1:0] {
        ST_OK             = 4'd0,
        ST_INVALID_OPCODE = 4'd1,
        ST_OUT_OF_MEMORY  = 4'd2,
        ST_INVALID_COUNT  = 4'd3
    } status_e;

    localparam int COUNT_W = 12;            // 3 nibbles
    typedef logic [COUNT_W-1:0] count_t;

    // x, y, z as 32 bit words, then three 4 bit attributes
    localparam int VTX_W = 108;
    typedef logic [VTX_W-1:0] vertex_t;

    // three 12 bit vertex indices
    localparam int TRI_W = 36;
    typedef logic [TRI_W-1:0] triangle_t;

    localparam int BUF_ID_W = 8;
    typedef logic [BUF_ID_W-1:0] buf_id_t;  // wraps at 256

endpackage

// File: rtl/nibble_shifter.sv
`timescale 1ns/1ps

module nibble_shifter #(
    parameter type payload_t = qspi_pkg::count_t
) (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          shift_en,
    input  logic [qspi_pkg::NIBBLE_W-1:0] nibble,
    output payload_t                      data,
    output logic                          last
);
    import qspi_pkg::*;

    localparam int W     = $bits(payload_t);
    localparam int N     = W / NIBBLE_W;
    localparam int CNT_W = $clog2(N + 1);

    logic [W-1:0]     shreg;
    logic [CNT_W-1:0] nib_cnt;

    // high while the final nibble of a word is on the bus
    assign last = shift_en && (nib_cnt == CNT_W'(N - 1));
    assign data = payload_t'(shreg);

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            nib_cnt <= '0;
        end else if (last) begin
            nib_cnt <= '0;
        end else if (shift_en) begin
            nib_cnt <= nib_cnt + 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (shift_en) begin
            shreg <= {shreg[W-NIBBLE_W-1:0], nibble};  // msb first
        end
    end

    a_whole_nibbles: assert property (@(posedge sck) (W % NIBBLE_W) == 0)
        else $error("payload width %0d is not a whole number of nibbles", W);

endmodule

// File: rtl/buffer_allocator.sv
`timescale 1ns/1ps

module buffer_allocator #(
    parameter int  CAPACITY = 8192,
    localparam int ADDR_W   = $clog2(CAPACITY + 1)
) (
    input  logic              sck,
    input  logic              rst,
    input  logic              request,
    input  qspi_pkg::count_t  count,
    output qspi_pkg::buf_id_t next_id,
    output logic [ADDR_W-1:0] next_base,
    output logic              fits
);
    import qspi_pkg::*;

    // one spare bit so the end address cannot wrap
    localparam int SUM_W = (ADDR_W > COUNT_W ? ADDR_W : COUNT_W) + 1;

    logic [SUM_W-1:0] end_addr;

    assign end_addr = SUM_W'(next_base) + SUM_W'(count);
    assign fits     = end_addr <= SUM_W'(CAPACITY);

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            next_id   <= '0;
            next_base <= '0;
        end else if (request && fits) begin
            next_id   <= next_id + 1'b1;
            next_base <= ADDR_W'(end_addr);
        end
    end

    // pool fills up to the last entry and no further
    a_base_in_pool: assert property (@(posedge sck) disable iff (rst)
        next_base <= ADDR_W'(CAPACITY));

endmodule

// File: rtl/reply_serializer.sv
`timescale 1ns/1ps

module reply_serializer (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          with_id,
    input  qspi_pkg::buf_id_t             id,
    input  qspi_pkg::status_e             status,
    output logic [qspi_pkg::NIBBLE_W-1:0] spi_out,
    output logic                          spi_oe,
    output logic                          busy
);
    import qspi_pkg::*;

    logic [1:0] left;       // nibbles still to drive, current one included
    buf_id_t    id_r;
    status_e    status_r;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            left <= '0;
        end else if (start) begin
            left <= with_id ? 2'd3 : 2'd1;
        end else if (left != '0) begin
            left <= left - 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (start) begin
            id_r     <= id;
            status_r <= status;
        end
    end

    always_comb begin
        case (left)
            2'd3:    spi_out = id_r[BUF_ID_W-1:NIBBLE_W];  // upper id nibble first
            2'd2:    spi_out = id_r[NIBBLE_W-1:0];
            2'd1:    spi_out = status_r;
            default: spi_out = '0;
        endcase
    end

    assign spi_oe = left != '0;
    assign busy   = spi_oe;

    // the command FSM must hold off until the previous reply is out
    a_no_overlap: assert property (@(posedge sck) disable iff (rst) start |-> !busy);

endmodule

// File: rtl/geometry_cmd_fsm.sv
`timescale 1ns/1ps

module geometry_cmd_fsm #(
    parameter int  SETTLE_CYCLES = 8,
    parameter int  MAX_VERT      = 8192,
    parameter int  MAX_TRI       = 8192,
    localparam int VADDR_W       = $clog2(MAX_VERT + 1),
    localparam int TADDR_W       = $clog2(MAX_TRI + 1),
    localparam int BASE_W        = VADDR_W > TADDR_W ? VADDR_W : TADDR_W
) (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          cs_n,
    input  logic [qspi_pkg::NIBBLE_W-1:0] spi_in,
    input  logic                          count_last,
    input  logic                          elem_last,
    input  qspi_pkg::count_t              count,
    input  logic                          vert_fits,
    input  logic                          tri_fits,
    input  qspi_pkg::buf_id_t             vert_next_id,
    input  qspi_pkg::buf_id_t             tri_next_id,
    input  logic [VADDR_W-1:0]            vert_next_base,
    input  logic [TADDR_W-1:0]            tri_next_base,
    input  logic                          reply_busy,
    output logic                          count_shift,
    output logic                          vert_shift,
    output logic                          tri_shift,
    output logic                          vert_request,
    output logic                          tri_request,
    output logic                          reply_start,
    output logic                          reply_with_id,
    output qspi_pkg::buf_id_t             reply_id,
    output qspi_pkg::status_e             reply_status,
    output logic                          vert_hdr_valid,
    output logic                          tri_hdr_valid,
    output logic                          vert_valid,
    output logic                          tri_valid,
    output qspi_pkg::buf_id_t             hdr_id,
    output logic [BASE_W-1:0]             hdr_base,
    output qspi_pkg::count_t              hdr_count
);
    import qspi_pkg::*;

    localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);

    typedef enum logic [1:0] {
        S_OPCODE,
        S_COUNT,
        S_CHECK,    // one edge to look at the full count
        S_PAYLOAD
    } state_e;

    state_e              state;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                settled;
    logic                sample;
    logic                bad_op;
    logic                check;
    logic                is_tri;
    logic                oom;        // payload drained but not stored
    logic                fits;
    logic                elem_done;
    logic                final_elem;
    count_t              elem_cnt;
    buf_id_t             next_id;
    logic [BASE_W-1:0]   next_base;

    // cs_n low for SETTLE_CYCLES edges before the first sample
    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            settle_cnt <= '0;
            settled    <= 1'b0;
        end else if (cs_n) begin
            settle_cnt <= '0;
            settled    <= 1'b0;
        end else if (!settled) begin
            if (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1)) begin
                settled <= 1'b1;
            end else begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    assign sample     = !cs_n && settled && !reply_busy;  // host bus is ours
    assign bad_op     = !(spi_in inside {OP_IDLE, OP_CREATE_VERT, OP_CREATE_TRI});
    assign check      = (state == S_CHECK) && !cs_n;
    assign fits       = is_tri ? tri_fits : vert_fits;
    assign next_id    = is_tri ? tri_next_id : vert_next_id;
    assign next_base  = is_tri ? BASE_W'(tri_next_base) : BASE_W'(vert_next_base);
    assign elem_done  = sample && (state == S_PAYLOAD) && elem_last;
    assign final_elem = elem_cnt == hdr_count - 1'b1;

    assign count_shift = sample && (state == S_COUNT);
    assign vert_shift  = sample && (state == S_PAYLOAD) && !is_tri;
    assign tri_shift   = sample && (state == S_PAYLOAD) && is_tri;

    assign vert_request = check && !is_tri && (count != '0) && fits;
    assign tri_request  = check && is_tri && (count != '0) && fits;

    always_comb begin
        reply_start   = 1'b0;
        reply_with_id = 1'b1;
        reply_id      = hdr_id;
        reply_status  = oom ? ST_OUT_OF_MEMORY : ST_OK;
        case (state)
            S_OPCODE: begin
                reply_start   = sample && bad_op;
                reply_with_id = 1'b0;
                reply_status  = ST_INVALID_OPCODE;
            end
            S_CHECK: begin
                reply_start  = check && (count == '0);
                reply_id     = next_id;    // nothing allocated
                reply_status = ST_INVALID_COUNT;
            end
            S_PAYLOAD: reply_start = elem_done && final_elem;
            default:   reply_start = 1'b0;
        endcase
    end

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state          <= S_OPCODE;
            is_tri         <= 1'b0;
            oom            <= 1'b0;
            elem_cnt       <= '0;
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
        end else begin
            vert_hdr_valid <= vert_request;
            tri_hdr_valid  <= tri_request;
            vert_valid     <= elem_done && !is_tri && !oom;
            tri_valid      <= elem_done && is_tri && !oom;
            if (cs_n) begin
                state <= S_OPCODE;
            end else begin
                case (state)
                    S_OPCODE: begin
                        if (sample && (spi_in == OP_CREATE_VERT || spi_in == OP_CREATE_TRI)) begin
                            is_tri <= spi_in == OP_CREATE_TRI;
                            state  <= S_COUNT;
                        end
                    end
                    S_COUNT: begin
                        if (count_shift && count_last) begin
                            state <= S_CHECK;
                        end
                    end
                    S_CHECK: begin
                        oom      <= !fits;
                        elem_cnt <= '0;
                        state    <= (count == '0) ? S_OPCODE : S_PAYLOAD;
                    end
                    S_PAYLOAD: begin
                        if (elem_done && final_elem) begin
                            state <= S_OPCODE;
                        end else if (elem_done) begin
                            elem_cnt <= elem_cnt + 1'b1;
                        end
                    end
                    default: state <= S_OPCODE;
                endcase
            end
        end
    end

    // header fields, held for the whole payload
    always_ff @(posedge sck) begin
        if (check) begin
            hdr_id    <= next_id;
            hdr_base  <= next_base;
            hdr_count <= count;
        end
    end

    a_one_elem_strobe: assert property (@(posedge sck) disable iff (rst)
        !(vert_valid && tri_valid));

    a_quiet_during_reply: assert property (@(posedge sck) disable iff (rst)
        reply_busy |-> !(count_shift || vert_shift || tri_shift));

endmodule

// File: rtl/qspi_geometry_loader.sv
`timescale 1ns/1ps

module qspi_geometry_loader #(
    parameter int  MAX_VERT      = 8192,
    parameter int  MAX_TRI       = 8192,
    parameter int  SETTLE_CYCLES = 8,
    localparam int VADDR_W       = $clog2(MAX_VERT + 1),
    localparam int TADDR_W       = $clog2(MAX_TRI + 1),
    localparam int BASE_W        = VADDR_W > TADDR_W ? VADDR_W : TADDR_W
) (
    input  logic                          sck,
    input  logic                          rst,
    input  logic                          cs_n,
    input  logic [qspi_pkg::NIBBLE_W-1:0] spi_in,
    output logic [qspi_pkg::NIBBLE_W-1:0] spi_out,
    output logic                          spi_oe,
    output logic                          vert_hdr_valid,
    output logic                          tri_hdr_valid,
    output logic                          vert_valid,
    output logic                          tri_valid,
    output qspi_pkg::vertex_t             vert_data,
    output qspi_pkg::triangle_t           tri_data,
    output qspi_pkg::buf_id_t             buf_id,
    output logic [BASE_W-1:0]             buf_base,
    output qspi_pkg::count_t              buf_count
);
    import qspi_pkg::*;

    logic               count_shift;
    logic               vert_shift;
    logic               tri_shift;
    logic               count_last;
    logic               vert_last;
    logic               tri_last;
    logic               elem_last;
    count_t             count;
    logic               vert_request;
    logic               tri_request;
    logic               vert_fits;
    logic               tri_fits;
    buf_id_t            vert_next_id;
    buf_id_t            tri_next_id;
    logic [VADDR_W-1:0] vert_next_base;
    logic [TADDR_W-1:0] tri_next_base;
    logic               reply_start;
    logic               reply_with_id;
    buf_id_t            reply_id;
    status_e            reply_status;
    logic               reply_busy;

    assign elem_last = vert_shift ? vert_last : tri_last;  // only one shifter runs

    geometry_cmd_fsm #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .MAX_VERT      (MAX_VERT),
        .MAX_TRI       (MAX_TRI)
    ) i_fsm (
        .sck            (sck),
        .rst            (rst),
        .cs_n           (cs_n),
        .spi_in         (spi_in),
        .count_last     (count_last),
        .elem_last      (elem_last),
        .count          (count),
        .vert_fits      (vert_fits),
        .tri_fits       (tri_fits),
        .vert_next_id   (vert_next_id),
        .tri_next_id    (tri_next_id),
        .vert_next_base (vert_next_base),
        .tri_next_base  (tri_next_base),
        .reply_busy     (reply_busy),
        .count_shift    (count_shift),
        .vert_shift     (vert_shift),
        .tri_shift      (tri_shift),
        .vert_request   (vert_request),
        .tri_request    (tri_request),
        .reply_start    (reply_start),
        .reply_with_id  (reply_with_id),
        .reply_id       (reply_id),
        .reply_status   (reply_status),
        .vert_hdr_valid (vert_hdr_valid),
        .tri_hdr_valid  (tri_hdr_valid),
        .vert_valid     (vert_valid),
        .tri_valid      (tri_valid),
        .hdr_id         (buf_id),
        .hdr_base       (buf_base),
        .hdr_count      (buf_count)
    );

    nibble_shifter #(.payload_t(count_t)) i_count_shifter (
        .sck      (sck),
        .rst      (rst),
        .shift_en (count_shift),
        .nibble   (spi_in),
        .data     (count),
        .last     (count_last)
    );

    nibble_shifter #(.payload_t(vertex_t)) i_vert_shifter (
        .sck      (sck),
        .rst      (rst),
        .shift_en (vert_shift),
        .nibble   (spi_in),
        .data     (vert_data),
        .last     (vert_last)
    );

    nibble_shifter #(.payload_t(triangle_t)) i_tri_shifter (
        .sck      (sck),
        .rst      (rst),
        .shift_en (tri_shift),
        .nibble   (spi_in),
        .data     (tri_data),
        .last     (tri_last)
    );

    buffer_allocator #(.CAPACITY(MAX_VERT)) i_vert_alloc (
        .sck       (sck),
        .rst       (rst),
        .request   (vert_request),
        .count     (count),
        .next_id   (vert_next_id),
        .next_base (vert_next_base),
        .fits      (vert_fits)
    );

    buffer_allocator #(.CAPACITY(MAX_TRI)) i_tri_alloc (
        .sck       (sck),
        .rst       (rst),
        .request   (tri_request),
        .count     (count),
        .next_id   (tri_next_id),
        .next_base (tri_next_base),
        .fits      (tri_fits)
    );

    reply_serializer i_reply (
        .sck     (sck),
        .rst     (rst),
        .start   (reply_start),
        .with_id (reply_with_id),
        .id      (reply_id),
        .status  (reply_status),
        .spi_out (spi_out),
        .spi_oe  (spi_oe),
        .busy    (reply_busy)
    );

endmodule

// File: testbench/tb_qspi_geometry_loader.sv
`timescale 1ns/1ps

module tb_qspi_geometry_loader;
    import qspi_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int SETTLE     = 8;
    localparam int VERT_CAP   = 64;
    localparam int VTX_NIBS   = VTX_W / NIBBLE_W;
    localparam int TRI_NIBS   = TRI_W / NIBBLE_W;
    localparam int N_CMDS     = 10;

    // opcode, element count, expected reply status
    localparam logic [3:0] CMD_OP [N_CMDS] = '{
        4'd1, 4'd2, 4'd2, 4'd1, 4'd1, 4'd4, 4'd3, 4'd1, 4'd0, 4'd2
    };
    localparam int CMD_COUNT [N_CMDS] = '{3, 2, 3, 62, 61, 0, 0, 0, 0, 1};
    localparam logic [3:0] CMD_STATUS [N_CMDS] = '{
        ST_OK, ST_OK, ST_OK, ST_OUT_OF_MEMORY, ST_OK,
        ST_INVALID_OPCODE, ST_INVALID_OPCODE, ST_INVALID_COUNT, ST_OK, ST_OK
    };

    typedef struct packed {
        buf_id_t     id;
        logic [13:0] base;
        count_t      count;
    } header_t;

    logic                sck;
    logic                rst;
    logic                cs_n;
    logic [NIBBLE_W-1:0] spi_in;
    logic [NIBBLE_W-1:0] spi_out;
    logic                spi_oe;
    logic                vert_hdr_valid;
    logic                tri_hdr_valid;
    logic                vert_valid;
    logic                tri_valid;
    vertex_t             vert_data;
    triangle_t           tri_data;
    buf_id_t             buf_id;
    logic [13:0]         buf_base;
    count_t              buf_count;

    // reference model state
    header_t     vhdr_q[$];
    header_t     thdr_q[$];
    vertex_t     vert_q[$];
    triangle_t   tri_q[$];
    buf_id_t     next_vid;
    buf_id_t     next_tid;
    int          next_vbase;
    int          next_tbase;
    header_t     mon_hdr;
    int unsigned lcg_state;

    qspi_geometry_loader #(.MAX_VERT(VERT_CAP)) i_dut (
        .sck            (sck),
        .rst            (rst),
        .cs_n           (cs_n),
        .spi_in         (spi_in),
        .spi_out        (spi_out),
        .spi_oe         (spi_oe),
        .vert_hdr_valid (vert_hdr_valid),
        .tri_hdr_valid  (tri_hdr_valid),
        .vert_valid     (vert_valid),
        .tri_valid      (tri_valid),
        .vert_data      (vert_data),
        .tri_data       (tri_data),
        .buf_id         (buf_id),
        .buf_base       (buf_base),
        .buf_count      (buf_count)
    );

    initial begin
        sck = 1'b0;
        forever #(CLK_PERIOD / 2) sck = ~sck;
    end

    function automatic logic [3:0] lcg_nibble();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:28];  // high bits have the longest period
    endfunction

    // cycles the whole table needs, reply included, plus reset and settle
    function automatic int run_cycles();
        int total;
        total = 4 + SETTLE + 2 + 50;
        for (int i = 0; i < N_CMDS; i++) begin
            if (CMD_OP[i] == OP_CREATE_VERT) begin
                total += 5 + CMD_COUNT[i] * VTX_NIBS;
            end else if (CMD_OP[i] == OP_CREATE_TRI) begin
                total += 5 + CMD_COUNT[i] * TRI_NIBS;
            end else begin
                total += 1;
            end
            total += 3;
        end
        return total;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time %0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // drive one nibble, return just after the edge that samples it
    task automatic send_nibble(input logic [3:0] nib);
        spi_in = nib;
        @(posedge sck);
        #1;
    endtask

    // nibs holds the reply in its low n nibbles, first nibble highest
    task automatic read_reply(input logic [11:0] nibs, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            check_value("spi_oe", 128'(spi_oe), 128'(1'b1));
            check_value("spi_out", 128'(spi_out), 128'(nibs[i*4 +: 4]));
            spi_in = 4'h0;
            @(posedge sck);
            #1;
        end
        check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
    endtask

    task automatic run_create(input logic [3:0] op, input int count, input logic [3:0] status);
        logic      is_tri;
        buf_id_t   id;
        int        base;
        int        nibs;
        count_t    cnt;
        vertex_t   vtx;
        triangle_t tri_word;
        logic [3:0] nib;
        is_tri = op == OP_CREATE_TRI;
        id     = is_tri ? next_tid : next_vid;
        base   = is_tri ? next_tbase : next_vbase;
        nibs   = is_tri ? TRI_NIBS : VTX_NIBS;
        cnt    = count_t'(count);
        if (status == ST_OK) begin
            if (is_tri) begin
                thdr_q.push_back(header_t'{id: id, base: 14'(base), count: cnt});
                next_tid   = next_tid + 1'b1;
                next_tbase = next_tbase + count;
            end else begin
                vhdr_q.push_back(header_t'{id: id, base: 14'(base), count: cnt});
                next_vid   = next_vid + 1'b1;
                next_vbase = next_vbase + count;
            end
        end
        send_nibble(op);
        check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
        for (int i = 2; i >= 0; i--) begin
            send_nibble(cnt[i*4 +: 4]);
            check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
        end
        send_nibble(4'h0);  // count check edge, nibble unused
        for (int e = 0; e < count; e++) begin
            vtx      = '0;
            tri_word = '0;
            for (int k = 0; k < nibs; k++) begin
                nib      = lcg_nibble();
                vtx      = {vtx[VTX_W-NIBBLE_W-1:0], nib};
                tri_word = {tri_word[TRI_W-NIBBLE_W-1:0], nib};
            end
            if (status == ST_OK && is_tri) begin
                tri_q.push_back(tri_word);
            end else if (status == ST_OK) begin
                vert_q.push_back(vtx);
            end
            for (int k = nibs - 1; k >= 0; k--) begin
                check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
                send_nibble(is_tri ? tri_word[k*4 +: 4] : vtx[k*4 +: 4]);
            end
        end
        read_reply({id, status}, 3);
        if (vert_q.size() != 0 || tri_q.size() != 0) begin
            abort_run($sformatf("element strobes missing after command opcode %0d", op));
        end
        if (vhdr_q.size() != 0 || thdr_q.size() != 0) begin
            abort_run($sformatf("header strobe missing after command opcode %0d", op));
        end
    endtask

    task automatic run_other(input logic [3:0] op, input logic [3:0] status);
        send_nibble(op);
        if (op == OP_IDLE) begin
            check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
        end else begin
            read_reply({8'h00, status}, 1);  // status only
        end
    endtask

    // header and element strobes against the model queues
    always @(negedge sck) begin
        if (!rst) begin
            if (vert_hdr_valid) begin
                if (vhdr_q.size() == 0) begin
                    abort_run("vertex header strobe arrived with none expected");
                end else begin
                    mon_hdr = vhdr_q.pop_front();
                    check_value("buf_id", 128'(buf_id), 128'(mon_hdr.id));
                    check_value("buf_base", 128'(buf_base), 128'(mon_hdr.base));
                    check_value("buf_count", 128'(buf_count), 128'(mon_hdr.count));
                end
            end
            if (tri_hdr_valid) begin
                if (thdr_q.size() == 0) begin
                    abort_run("triangle header strobe arrived with none expected");
                end else begin
                    mon_hdr = thdr_q.pop_front();
                    check_value("buf_id", 128'(buf_id), 128'(mon_hdr.id));
                    check_value("buf_base", 128'(buf_base), 128'(mon_hdr.base));
                    check_value("buf_count", 128'(buf_count), 128'(mon_hdr.count));
                end
            end
            if (vert_valid) begin
                if (vert_q.size() == 0) begin
                    abort_run("vert_valid strobe arrived with no vertex expected");
                end else begin
                    check_value("vert_data", 128'(vert_data), 128'(vert_q.pop_front()));
                end
            end
            if (tri_valid) begin
                if (tri_q.size() == 0) begin
                    abort_run("tri_valid strobe arrived with no triangle expected");
                end else begin
                    check_value("tri_data", 128'(tri_data), 128'(tri_q.pop_front()));
                end
            end
        end
    end

    initial begin
        #(run_cycles() * CLK_PERIOD);
        abort_run("watchdog timeout, the DUT stopped answering");
    end

    initial begin
        rst        = 1'b1;
        cs_n       = 1'b1;
        spi_in     = 4'h0;
        lcg_state  = 35939;
        next_vid   = '0;
        next_tid   = '0;
        next_vbase = 0;
        next_tbase = 0;
        repeat (4) @(posedge sck);
        #1;
        rst  = 1'b0;
        cs_n = 1'b0;
        check_value("spi_oe", 128'(spi_oe), 128'(1'b0));
        check_value("vert_hdr_valid", 128'(vert_hdr_valid), 128'(1'b0));
        check_value("tri_hdr_valid", 128'(tri_hdr_valid), 128'(1'b0));
        check_value("vert_valid", 128'(vert_valid), 128'(1'b0));
        check_value("tri_valid", 128'(tri_valid), 128'(1'b0));
        repeat (SETTLE + 2) @(posedge sck);  // idle nibbles while cs_n settles
        #1;
        for (int i = 0; i < N_CMDS; i++) begin
            if (CMD_OP[i] == OP_CREATE_VERT || CMD_OP[i] == OP_CREATE_TRI) begin
                run_create(CMD_OP[i], CMD_COUNT[i], CMD_STATUS[i]);
            end else begin
                run_other(CMD_OP[i], CMD_STATUS[i]);
            end
        end
        repeat (2) @(posedge sck);
        $display("test passed");
        $finish;
    end

endmodule

// File: qspi_geometry_loader.f
rtl/qspi_pkg.sv
rtl/nibble_shifter.sv
rtl/buffer_allocator.sv
rtl/reply_serializer.sv
rtl/geometry_cmd_fsm.sv
rtl/qspi_geometry_loader.sv
testbench/tb_qspi_geometry_loader.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_qspi_geometry_loader
FILELIST  ?= qspi_geometry_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
